// File: design/decFrontPkg.sv
/*
  Shared types for the decoder front end.
  Instruction word and marker tag typedefs, the fetch request and
  decoder word structs, the flush marker word and the default
  queue depth.
 */

`default_nettype none

package decFrontPkg;

	// one instruction word, XG3RV or XG2 encoding.
	typedef logic [31:0] istrWordT;

	// marker tag carried next to each word.
	typedef logic [1:0] mTagT;

	// word offered by the fetch unit.
	typedef struct packed
	{
		istrWordT istrWord;	// raw word.
		logic isXg3;		// word is in XG3RV encoding.
		logic isFlush;		// replace with flush marker.
	} fetchReqT;

	// word handed to the decoder.
	typedef struct packed
	{
		istrWordT istrWord;	// repacked or passed word.
		mTagT mTag;			// 1 when repacked or flushed.
	} decWordT;

	// marker word standing in for a flushed slot.
	localparam istrWordT FlushWord = 32'h3030_F000;

	// queue depth used unless the top level overrides it.
	localparam int QueueDepthDef = 4;

endpackage

`default_nettype wire

// File: design/decFetchPort.sv
/*
  Fetch side receiver.
  Four-phase req/ack handshake with a single ack flip-flop.
  Captures the offered fetch struct and pulses capValid when
  the queue has room.
 */

`timescale 1ns/1ps
`default_nettype none

module decFetchPort
(
	input logic clock,
	input logic rstN,
	input logic req,
	input decFrontPkg::fetchReqT fetchReq,
	output logic ack,
	input logic full,
	output logic capValid,
	output decFrontPkg::fetchReqT capReq
);

	logic accept;

	// new request, not yet acked, and a free slot.
	assign accept = req && !ack && !full;

	// handshake control.
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			ack <= 1'b0;
			capValid <= 1'b0;
		end
		else
		begin
			capValid <= accept;	// one cycle push strobe.
			if (accept)
			begin
				ack <= 1'b1;
			end
			else if (!req)
			begin
				ack <= 1'b0;	// release once fetch drops req.
			end
		end
	end

	// captured fetch struct.
	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			capReq <= fetchReq;
		end
	end

	// once acked, ack holds for as long as fetch keeps req up.
	property pAckHeld;
		@(posedge clock) disable iff (!rstN)
		(ack && req) |=> ack;
	endproperty

	aAckHeld: assert property (pAckHeld)
	else
		$error("decFetchPort: ack dropped while req still high");

	// fetch keeps req and its word steady until ack rises.
	property pReqHeld;
		@(posedge clock) disable iff (!rstN)
		(req && !ack) |=> (req && $stable(fetchReq));
	endproperty

	aReqHeld: assert property (pReqHeld)
	else
		$error("decFetchPort: req or fetch word changed before ack");

endmodule

`default_nettype wire

// File: design/decOpRepXg3.sv
/*
  XG3RV to XG2 instruction repackager.
  Builds the F0, F1, F8 and FE field layouts, picks one by bits 4:2,
  and applies the mode and flush overrides together with the tag.
 */

`timescale 1ns/1ps
`default_nettype none

module decOpRepXg3
(
	input decFrontPkg::fetchReqT capReq,
	output decFrontPkg::decWordT repWord
);

	import decFrontPkg::*;

	localparam logic [1:0] LayF0 = 2'd0;
	localparam logic [1:0] LayF1 = 2'd1;
	localparam logic [1:0] LayF8 = 2'd2;
	localparam logic [1:0] LayFE = 2'd3;

	istrWordT w;
	logic pSel;
	logic [4:0] modeBits;
	logic [1:0] laySel;
	istrWordT layF0;
	istrWordT layF1;
	istrWordT layF8;
	istrWordT layFE;
	istrWordT laySelWord;

	assign w = capReq.istrWord;

	// predicate bit, depends on the 16/32 bit form.
	always_comb
	begin
		if (!w[1])
		begin
			pSel = w[0];
		end
		else
		begin
			pSel = (w[4:3] == 2'b11);
		end
	end

	// mode field common to every layout.
	assign modeBits = {w[1], w[4], pSel, w[3:2]};

	// register form, high immediate bits.
	assign layF0 =
	{
		w[15:12], w[5], w[10], w[20], w[26], w[25:22], w[31:28],
		~w[11], ~w[21], ~w[27], modeBits, w[9:6], w[19:16]
	};

	// register form, alternate immediate order.
	assign layF1 =
	{
		w[15:12], w[5], w[10], w[20], w[30:27], w[26], w[25:22],
		~w[11], ~w[21], ~w[31], modeBits, w[9:6], w[19:16]
	};

	// upper half kept as is.
	assign layF8 =
	{
		w[31:16],
		~w[11], ~w[15], ~w[5], modeBits,
		w[14:12], w[10], w[9:6]
	};

	// upper half kept, low byte pair swapped down.
	assign layFE =
	{
		w[31:16],
		~w[7], ~w[6], ~w[5], modeBits,
		w[15:8]
	};

	// layout choice from bits 4:2.
	always_comb
	begin
		unique case (w[4:2])
			3'b000, 3'b011, 3'b101: laySel = LayF0;
			3'b001, 3'b010: laySel = LayF1;
			3'b100: laySel = LayF8;
			default: laySel = LayFE;	// 110 and 111.
		endcase
	end

	always_comb
	begin
		unique case (laySel)
			LayF0: laySelWord = layF0;
			LayF1: laySelWord = layF1;
			LayF8: laySelWord = layF8;
			default: laySelWord = layFE;
		endcase
	end

	// flush wins over mode; 32-bit XG3 words (low bits 11) pass.
	always_comb
	begin
		if (capReq.isFlush)
		begin
			repWord.istrWord = FlushWord;
			repWord.mTag = mTagT'(1);
		end
		else if (capReq.isXg3 && (w[1:0] != 2'b11))
		begin
			repWord.istrWord = laySelWord;
			repWord.mTag = mTagT'(1);
		end
		else
		begin
			repWord.istrWord = w;
			repWord.mTag = mTagT'(0);
		end
	end

endmodule

`default_nettype wire

// File: design/decOpQueue.sv
/*
  Circular queue of repacked words toward the decoder.
  Read and write pointers with an occupancy count, full for
  back-pressure on the fetch side and valid/ready on the output.
 */

`timescale 1ns/1ps
`default_nettype none

module decOpQueue
#(
	parameter int QueueDepth = decFrontPkg::QueueDepthDef
)
(
	input logic clock,
	input logic rstN,
	input logic push,
	input decFrontPkg::decWordT pushWord,
	output logic full,
	output logic outValid,
	input logic outReady,
	output decFrontPkg::decWordT outWord
);

	import decFrontPkg::*;

	localparam int PtrW = $clog2(QueueDepth);
	localparam int CntW = $clog2(QueueDepth + 1);

	typedef logic [PtrW-1:0] ptrT;
	typedef logic [CntW-1:0] cntT;

	decWordT mem [QueueDepth];
	ptrT rdPtr;
	ptrT wrPtr;
	cntT count;
	logic doPush;
	logic doPop;

	// pointers wrap on their own, so depth must be a power of two.
	if ((QueueDepth < 2) || ((QueueDepth & (QueueDepth - 1)) != 0))
	begin : gDepthCheck
		$error("decOpQueue: QueueDepth must be a power of two of at least 2");
	end

	assign full = (count == cntT'(QueueDepth));
	assign outValid = (count != '0);
	assign outWord = mem[rdPtr];

	assign doPush = push && !full;
	assign doPop = outValid && outReady;

	// storage, payload only.
	always_ff @(posedge clock)
	begin
		if (doPush)
		begin
			mem[wrPtr] <= pushWord;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + ptrT'(1);
			if (doPop)
				rdPtr <= rdPtr + ptrT'(1);
			case ({doPush, doPop})
				2'b10: count <= count + cntT'(1);
				2'b01: count <= count - cntT'(1);
				default: count <= count;	// none, or both at once.
			endcase
		end
	end

	// the fetch port must hold off while the queue is full.
	aNoPushFull: assert property (@(posedge clock) disable iff (!rstN)
		push |-> !full)
	else
		$error("decOpQueue: push while full");

	// stalled output keeps both valid and data.
	aOutHeld: assert property (@(posedge clock) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outWord)))
	else
		$error("decOpQueue: output changed while stalled");

endmodule

`default_nettype wire

// File: design/decFront.sv
/*
  Decoder front end top level.
  Fetch port, XG3 repackager and output queue wired in a chain.
 */

`timescale 1ns/1ps
`default_nettype none

module decFront
#(
	parameter int QueueDepth = decFrontPkg::QueueDepthDef
)
(
	input logic clock,
	input logic rstN,
	input logic req,
	input decFrontPkg::fetchReqT fetchReq,
	output logic ack,
	output logic outValid,
	input logic outReady,
	output decFrontPkg::decWordT outWord
);

	import decFrontPkg::*;

	logic full;
	logic capValid;
	fetchReqT capReq;
	decWordT repWord;

	// handshake and capture.
	decFetchPort uFetch
	(
		.clock(clock),
		.rstN(rstN),
		.req(req),
		.fetchReq(fetchReq),
		.ack(ack),
		.full(full),
		.capValid(capValid),
		.capReq(capReq)
	);

	// zero-cycle repack of the captured word.
	decOpRepXg3 uRep
	(
		.capReq(capReq),
		.repWord(repWord)
	);

	decOpQueue #(
		.QueueDepth(QueueDepth)
	) uQueue
	(
		.clock(clock),
		.rstN(rstN),
		.push(capValid),
		.pushWord(repWord),
		.full(full),
		.outValid(outValid),
		.outReady(outReady),
		.outWord(outWord)
	);

endmodule

`default_nettype wire

// File: dv/tbDecFrontTasks.svh
/*
  Testbench tasks for the decoder front end.
  Value check, four-phase send, output receive and the
  directed tests.
 */

// compare and log a mismatch.
task automatic checkVal(string name, logic [63:0] got, logic [63:0] exp);
	checkCount++;
	if (got !== exp)
	begin
		errCount++;
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
	end
endtask

// wait for ack, drop req, wait for ack to fall.
task automatic finishHandshake();
	@(posedge clock);
	while (!ack) @(posedge clock);
	req <= 1'b0;
	@(posedge clock);
	while (ack) @(posedge clock);
endtask

task automatic sendWord(fetchReqT f);
	@(posedge clock);
	fetchReq <= f;
	req <= 1'b1;
	finishHandshake();
endtask

// one transfer, then compare both fields.
task automatic expectWord(decWordT exp);
	@(posedge clock);
	while (!(outValid && outReady)) @(posedge clock);
	checkVal("outWord.istrWord", 64'(outWord.istrWord), 64'(exp.istrWord));
	checkVal("outWord.mTag", 64'(outWord.mTag), 64'(exp.mTag));
endtask

// queue holds the word until outReady rises.
task automatic sendAndReceive(fetchReqT f, decWordT exp);
	sendWord(f);
	outReady <= 1'b1;
	expectWord(exp);
	outReady <= 1'b0;
endtask

task automatic resetState();
	@(posedge clock);
	checkVal("ack", 64'(ack), 64'd0);
	checkVal("outValid", 64'(outValid), 64'd0);
endtask

task automatic passThroughWords();
	fetchReqT f;
	decWordT exp;
	for (int i = 0; i < 8; i++)
	begin
		f.istrWord = $random(seed);
		f.isXg3 = (i >= 4);	// second half in XG3 mode.
		f.isFlush = 1'b0;
		if (i >= 4)
			f.istrWord[1:0] = 2'b11;	// 32-bit XG3 form.
		exp.istrWord = f.istrWord;
		exp.mTag = 2'd0;
		sendAndReceive(f, exp);
	end
endtask

task automatic layoutSelection();
	fetchReqT f;
	for (int s = 0; s < 8; s++)
	begin
		for (int k = 0; k < 3; k++)
		begin
			f.istrWord = $random(seed);
			f.istrWord[4:2] = 3'(s);
			f.istrWord[1:0] = 2'(k);	// 00, 01, 10 cover both predicate forms.
			f.isXg3 = 1'b1;
			f.isFlush = 1'b0;
			sendAndReceive(f, refRepack(f));
		end
	end
endtask

task automatic flushWords();
	fetchReqT f;
	decWordT exp;
	for (int i = 0; i < 4; i++)
	begin
		f.istrWord = $random(seed);
		f.isXg3 = i[0];
		f.isFlush = 1'b1;
		exp.istrWord = FlushWord;
		exp.mTag = 2'd1;
		sendAndReceive(f, exp);
	end
endtask

task automatic burstOrdering();
	fetchReqT burst [20];
	istrWordT rnd;
	for (int i = 0; i < 20; i++)
	begin
		rnd = $random(seed);
		burst[i].istrWord = $random(seed);
		burst[i].isXg3 = rnd[0];
		burst[i].isFlush = ((i % 7) == 3);
	end
	outReady <= 1'b1;
	fork
		for (int i = 0; i < 20; i++)
			sendWord(burst[i]);
		for (int j = 0; j < 20; j++)
			expectWord(refRepack(burst[j]));
	join
	outReady <= 1'b0;
endtask

task automatic backPressure();
	fetchReqT words [TbDepth + 1];
	logic ackSeen;
	for (int i = 0; i <= TbDepth; i++)
	begin
		words[i].istrWord = $random(seed);
		words[i].isXg3 = 1'b1;
		words[i].isFlush = 1'b0;
	end
	ackSeen = 1'b0;
	outReady <= 1'b0;
	for (int i = 0; i < TbDepth; i++)
		sendWord(words[i]);
	// queue full, this request must wait.
	@(posedge clock);
	fetchReq <= words[TbDepth];
	req <= 1'b1;
	repeat (20)
	begin
		@(posedge clock);
		ackSeen = ackSeen | ack;
	end
	checkVal("ack", 64'(ackSeen), 64'd0);
	outReady <= 1'b1;
	fork
		finishHandshake();
		for (int j = 0; j <= TbDepth; j++)
			expectWord(refRepack(words[j]));
	join
	outReady <= 1'b0;
endtask

// File: dv/tbDecFront.sv
/*
  Testbench top for the decoder front end.
  Clock, reset, DUT instance, cycle timeout, reference repack
  model and the closing summary.
 */

`timescale 1ns/1ps
`default_nettype none

module tbDecFront;

	import decFrontPkg::*;

	localparam int TbDepth = 4;
	localparam int TimeoutCycles = 4000;	// about ten times the longest test.

	logic clock = 1'b0;
	logic rstN;
	logic req;
	fetchReqT fetchReq;
	logic ack;
	logic outValid;
	logic outReady;
	decWordT outWord;

	integer seed;
	int errCount;
	int checkCount;
	int cycleCount = 0;

	decFront #(
		.QueueDepth(TbDepth)
	) i_decFront
	(
		.clock(clock),
		.rstN(rstN),
		.req(req),
		.fetchReq(fetchReq),
		.ack(ack),
		.outValid(outValid),
		.outReady(outReady),
		.outWord(outWord)
	);

	always #5 clock = ~clock;	// 10 ns period.

	// expected decoder word for one fetch request.
	function automatic decWordT refRepack(fetchReqT f);
		istrWordT w;
		istrWordT r;
		decWordT d;
		w = f.istrWord;
		r = '0;
		r[12] = w[1];
		r[11] = w[4];
		r[10] = w[1] ? (w[4] & w[3]) : w[0];	// predicate.
		r[9:8] = w[3:2];
		case (w[4:2])
			3'b100:
			begin
				r[31:16] = w[31:16];	// F8.
				r[15] = ~w[11];
				r[14] = ~w[15];
				r[13] = ~w[5];
				r[7:5] = w[14:12];
				r[4] = w[10];
				r[3:0] = w[9:6];
			end
			3'b110, 3'b111:
			begin
				r[31:16] = w[31:16];	// FE.
				r[15] = ~w[7];
				r[14] = ~w[6];
				r[13] = ~w[5];
				r[7:0] = w[15:8];
			end
			default:
			begin
				r[31:28] = w[15:12];	// fields shared by F0 and F1.
				r[27] = w[5];
				r[26] = w[10];
				r[25] = w[20];
				r[15] = ~w[11];
				r[14] = ~w[21];
				r[7:4] = w[9:6];
				r[3:0] = w[19:16];
				if ((w[4:2] == 3'b001) || (w[4:2] == 3'b010))
				begin
					r[24:21] = w[30:27];	// F1.
					r[20] = w[26];
					r[19:16] = w[25:22];
					r[13] = ~w[31];
				end
				else
				begin
					r[24] = w[26];	// F0.
					r[23:20] = w[25:22];
					r[19:16] = w[31:28];
					r[13] = ~w[27];
				end
			end
		endcase
		if (f.isFlush)
		begin
			d.istrWord = FlushWord;
			d.mTag = 2'd1;
		end
		else if (f.isXg3 && (w[1:0] != 2'b11))
		begin
			d.istrWord = r;
			d.mTag = 2'd1;
		end
		else
		begin
			d.istrWord = w;
			d.mTag = 2'd0;
		end
		return d;
	endfunction

	`include "tbDecFrontTasks.svh"

	// ends a run whose handshake never completes.
	initial
	begin : timeoutWatch
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge clock);
			cycleCount = cycleCount + 1;
		end
		$display("tbDecFront: timeout after %0d cycles, a handshake never finished",
			cycleCount);
		$display("tbDecFront: %0d checks, %0d errors", checkCount, errCount);
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		seed = 32'h076a_0c28;
		errCount = 0;
		checkCount = 0;
		rstN = 1'b0;
		req = 1'b0;
		fetchReq = '0;
		outReady = 1'b0;
		repeat (3) @(posedge clock);
		rstN <= 1'b1;
		resetState();
		passThroughWords();
		layoutSelection();
		flushWords();
		burstOrdering();
		backPressure();
		$display("tbDecFront: %0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
design/decFrontPkg.sv
design/decFetchPort.sv
design/decOpRepXg3.sv
design/decOpQueue.sv
design/decFront.sv
+incdir+dv
dv/tbDecFront.sv

// File: Makefile
# Verilator build and run of the decoder front end testbench.

VERILATOR ?= verilator
TOP ?= tbDecFront
FLIST ?= vlog.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASSMSG ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- '$(PASSMSG)'

clean:
	rm -rf $(OBJDIR)
